//--- source/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

  typedef enum logic [1:0] {
    ROM   = 2'd0,
    RAM   = 2'd1,
    CLINT = 2'd2,
    NONE  = 2'd3
  } region_e;

  // --------------------------------------
  // Address map
  // --------------------------------------
  localparam logic [31:0] RomBase     = 32'h0001_0000;
  localparam logic [31:0] RomLength   = 32'h0000_1000;
  localparam logic [31:0] RamBase     = 32'h8000_0000;
  localparam logic [31:0] ClintBase   = 32'h0200_0000;
  localparam logic [31:0] ClintLength = 32'h0000_C000;

  // Offsets within the CLINT region
  localparam logic [31:0] MsipOffset     = 32'h0000_0000;
  localparam logic [31:0] MtimecmpOffset = 32'h0000_4000;
  localparam logic [31:0] MtimeOffset    = 32'h0000_BFF8;

  // --------------------------------------
  // Boot ROM image
  // --------------------------------------
  localparam int RomWords = 8;

  localparam logic [0:RomWords-1][63:0] BootRomImage = '{
    64'hf140_2573_0000_0297,
    64'h0202_8593_0182_b283,
    64'h0000_0013_0002_80e7,
    64'h3040_1073_1050_0073,
    64'hffdf_f06f_0000_0013,
    64'h8000_0000_0000_0000,
    64'h0000_1020_dead_beef,
    64'h0123_4567_89ab_cdef
  };

endpackage

`default_nettype wire

//--- source/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // Request, and access to a target with addr as region offset
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    resp_e                resp;
  } bus_rsp_t;

  // Replace the bytes of old_data that are selected by be
  function automatic logic [DataWidth-1:0] be_merge(
    input logic [DataWidth-1:0] old_data,
    input logic [DataWidth-1:0] new_data,
    input logic [StrbWidth-1:0] be
  );
    logic [DataWidth-1:0] res;
    res = old_data;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_data[b*8 +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- source/req_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module req_decoder #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output logic                  rom_valid_o,
  output logic                  ram_valid_o,
  output logic                  clint_valid_o,
  output soc_bus_pkg::bus_req_t acc_o,
  output logic                  err_valid_o,
  output soc_bus_pkg::resp_e    err_resp_o
);

  localparam logic [31:0] RamLength = 32'(NumWords * soc_bus_pkg::StrbWidth);

  soc_map_pkg::region_e                region;
  logic [soc_bus_pkg::AddrWidth-1:0]   base;
  soc_bus_pkg::bus_req_t               acc_d;

  // Start and end address per region
  always_comb begin
    region = soc_map_pkg::NONE;
    base   = '0;
    if (req_i.addr >= soc_map_pkg::RomBase &&
        req_i.addr <= soc_map_pkg::RomBase + soc_map_pkg::RomLength - 1) begin
      region = soc_map_pkg::ROM;
      base   = soc_map_pkg::RomBase;
    end else if (req_i.addr >= soc_map_pkg::RamBase &&
                 req_i.addr <= soc_map_pkg::RamBase + RamLength - 1) begin
      region = soc_map_pkg::RAM;
      base   = soc_map_pkg::RamBase;
    end else if (req_i.addr >= soc_map_pkg::ClintBase &&
                 req_i.addr <= soc_map_pkg::ClintBase + soc_map_pkg::ClintLength - 1) begin
      region = soc_map_pkg::CLINT;
      base   = soc_map_pkg::ClintBase;
    end
  end

  always_comb begin
    acc_d      = req_i;
    acc_d.addr = req_i.addr - base;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rom_valid_o   <= 1'b0;
      ram_valid_o   <= 1'b0;
      clint_valid_o <= 1'b0;
      err_valid_o   <= 1'b0;
    end else begin
      rom_valid_o   <= req_valid_i && region == soc_map_pkg::ROM && !req_i.we;
      ram_valid_o   <= req_valid_i && region == soc_map_pkg::RAM;
      clint_valid_o <= req_valid_i && region == soc_map_pkg::CLINT;
      // ROM is read only
      err_valid_o   <= req_valid_i && (region == soc_map_pkg::NONE ||
                                       (region == soc_map_pkg::ROM && req_i.we));
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      acc_o      <= acc_d;
      err_resp_o <= (region == soc_map_pkg::NONE) ? soc_bus_pkg::DECERR : soc_bus_pkg::SLVERR;
    end
  end

endmodule

`default_nettype wire

//--- source/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              valid_i,
  input  soc_bus_pkg::bus_req_t             acc_i,
  output logic                              rd_valid_o,
  output logic [soc_bus_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned ByteBits = $clog2(soc_bus_pkg::StrbWidth);
  localparam int unsigned IdxWidth = soc_bus_pkg::AddrWidth - ByteBits;
  localparam int unsigned SelWidth = $clog2(soc_map_pkg::RomWords);

  logic [IdxWidth-1:0] idx;

  // Word index from the byte offset
  assign idx = acc_i.addr[soc_bus_pkg::AddrWidth-1:ByteBits];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      if (idx < IdxWidth'(soc_map_pkg::RomWords)) begin
        rdata_o <= soc_map_pkg::BootRomImage[idx[SelWidth-1:0]];
      end else begin
        // Past the image
        rdata_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              valid_i,
  input  soc_bus_pkg::bus_req_t             acc_i,
  output logic                              rd_valid_o,
  output logic [soc_bus_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned ByteBits = $clog2(soc_bus_pkg::StrbWidth);
  localparam int unsigned IdxWidth = $clog2(NumWords);

  logic [soc_bus_pkg::DataWidth-1:0] mem_q [NumWords];
  logic [IdxWidth-1:0]               idx;

  assign idx = acc_i.addr[IdxWidth+ByteBits-1:ByteBits];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= valid_i;
    end
  end

  // --------------------------------------
  // Storage and read port
  // --------------------------------------
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      if (acc_i.we) begin
        mem_q[idx] <= soc_bus_pkg::be_merge(mem_q[idx], acc_i.wdata, acc_i.be);
        // Write reply has no data
        rdata_o    <= '0;
      end else begin
        rdata_o    <= mem_q[idx];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              rtc_i,
  input  logic                              valid_i,
  input  soc_bus_pkg::bus_req_t             acc_i,
  output logic                              rd_valid_o,
  output logic [soc_bus_pkg::DataWidth-1:0] rdata_o,
  output logic                              timer_irq_o,
  output logic                              ipi_o
);

  localparam int unsigned ByteBits = $clog2(soc_bus_pkg::StrbWidth);

  logic [2:0]                          rtc_sync_q;
  logic                                rtc_tick;
  logic [63:0]                         mtime_q;
  logic [63:0]                         mtimecmp_q;
  logic                                msip_q;
  logic [soc_bus_pkg::AddrWidth-1:0]   word_addr;
  logic                                sel_msip;
  logic                                sel_cmp;
  logic                                sel_time;
  logic                                wr;
  logic [soc_bus_pkg::DataWidth-1:0]   rdata_d;

  // Two flops into the clk_i domain and a third for edge detection
  assign rtc_tick = rtc_sync_q[1] & ~rtc_sync_q[2];

  assign word_addr = {acc_i.addr[soc_bus_pkg::AddrWidth-1:ByteBits], ByteBits'(0)};
  assign sel_msip  = word_addr == soc_map_pkg::MsipOffset;
  assign sel_cmp   = word_addr == soc_map_pkg::MtimecmpOffset;
  assign sel_time  = word_addr == soc_map_pkg::MtimeOffset;
  assign wr        = valid_i & acc_i.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      rd_valid_o <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
      // Software write beats the tick
      if (wr && sel_time) begin
        mtime_q <= soc_bus_pkg::be_merge(mtime_q, acc_i.wdata, acc_i.be);
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr && sel_cmp) begin
        mtimecmp_q <= soc_bus_pkg::be_merge(mtimecmp_q, acc_i.wdata, acc_i.be);
      end
      if (wr && sel_msip && acc_i.be[0]) begin
        msip_q <= acc_i.wdata[0];
      end
      rd_valid_o <= valid_i;
    end
  end

  always_comb begin
    rdata_d = '0;
    if (sel_msip) begin
      rdata_d = {63'd0, msip_q};
    end else if (sel_cmp) begin
      rdata_d = mtimecmp_q;
    end else if (sel_time) begin
      rdata_d = mtime_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rdata_o <= acc_i.we ? '0 : rdata_d;
    end
  end

  assign timer_irq_o = mtime_q >= mtimecmp_q;
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

//--- source/rsp_mux.sv
`timescale 1ns/1ps
`default_nettype none

module rsp_mux (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              rom_valid_i,
  input  logic                              ram_valid_i,
  input  logic                              clint_valid_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] rom_rdata_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] ram_rdata_i,
  input  logic [soc_bus_pkg::DataWidth-1:0] clint_rdata_i,
  input  logic                              err_valid_i,
  input  soc_bus_pkg::resp_e                err_resp_i,
  output logic                              rsp_valid_o,
  output soc_bus_pkg::bus_rsp_t             rsp_o
);

  logic               err_valid_q;
  soc_bus_pkg::resp_e err_resp_q;

  // Errors skip the target stage, so hold them one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= err_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_valid_i) begin
      err_resp_q <= err_resp_i;
    end
  end

  assign rsp_valid_o = rom_valid_i | ram_valid_i | clint_valid_i | err_valid_q;

  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.resp  = soc_bus_pkg::OKAY;
    if (err_valid_q) begin
      rsp_o.resp = err_resp_q;
    end else if (rom_valid_i) begin
      rsp_o.rdata = rom_rdata_i;
    end else if (ram_valid_i) begin
      rsp_o.rdata = ram_rdata_i;
    end else if (clint_valid_i) begin
      rsp_o.rdata = clint_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- source/soc_harness_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_harness_top #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rtc_i,
  input  logic                  req_valid_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output logic                  rsp_valid_o,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  output logic                  timer_irq_o,
  output logic                  ipi_o
);

  logic                              rom_valid;
  logic                              ram_valid;
  logic                              clint_valid;
  logic                              err_valid;
  soc_bus_pkg::resp_e                err_resp;
  soc_bus_pkg::bus_req_t             acc;
  logic                              rom_rd_valid;
  logic                              ram_rd_valid;
  logic                              clint_rd_valid;
  logic [soc_bus_pkg::DataWidth-1:0] rom_rdata;
  logic [soc_bus_pkg::DataWidth-1:0] ram_rdata;
  logic [soc_bus_pkg::DataWidth-1:0] clint_rdata;

  // --------------------------------------
  // Input side
  // --------------------------------------
  req_decoder #(
    .NumWords ( NumWords )
  ) i_req_decoder (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .req_valid_i   ( req_valid_i ),
    .req_i         ( req_i       ),
    .rom_valid_o   ( rom_valid   ),
    .ram_valid_o   ( ram_valid   ),
    .clint_valid_o ( clint_valid ),
    .acc_o         ( acc         ),
    .err_valid_o   ( err_valid   ),
    .err_resp_o    ( err_resp    )
  );

  // --------------------------------------
  // Targets
  // --------------------------------------
  boot_rom i_boot_rom (
    .clk_i      ( clk_i        ),
    .rst_ni     ( rst_ni       ),
    .valid_i    ( rom_valid    ),
    .acc_i      ( acc          ),
    .rd_valid_o ( rom_rd_valid ),
    .rdata_o    ( rom_rdata    )
  );

  data_ram #(
    .NumWords ( NumWords )
  ) i_data_ram (
    .clk_i      ( clk_i        ),
    .rst_ni     ( rst_ni       ),
    .valid_i    ( ram_valid    ),
    .acc_i      ( acc          ),
    .rd_valid_o ( ram_rd_valid ),
    .rdata_o    ( ram_rdata    )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .rtc_i       ( rtc_i          ),
    .valid_i     ( clint_valid    ),
    .acc_i       ( acc            ),
    .rd_valid_o  ( clint_rd_valid ),
    .rdata_o     ( clint_rdata    ),
    .timer_irq_o ( timer_irq_o    ),
    .ipi_o       ( ipi_o          )
  );

  // --------------------------------------
  // Output side
  // --------------------------------------
  rsp_mux i_rsp_mux (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .rom_valid_i   ( rom_rd_valid   ),
    .ram_valid_i   ( ram_rd_valid   ),
    .clint_valid_i ( clint_rd_valid ),
    .rom_rdata_i   ( rom_rdata      ),
    .ram_rdata_i   ( ram_rdata      ),
    .clint_rdata_i ( clint_rdata    ),
    .err_valid_i   ( err_valid      ),
    .err_resp_i    ( err_resp       ),
    .rsp_valid_o   ( rsp_valid_o    ),
    .rsp_o         ( rsp_o          )
  );

endmodule

`default_nettype wire

//--- testbench/soc_harness_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module soc_harness_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic req_valid_i,
  input logic rsp_valid_i
);

  // Count of failed assertions
  int n_errors = 0;

  // Each request gets its reply two edges later
  property req_to_rsp_p;
    @(posedge clk_i) disable iff (!rst_ni) req_valid_i |-> ##2 rsp_valid_i;
  endproperty

  // No reply without a request two cycles back
  property rsp_has_req_p;
    @(posedge clk_i) disable iff (!rst_ni) rsp_valid_i |-> $past(req_valid_i, 2);
  endproperty

  property quiet_in_reset_p;
    @(posedge clk_i) !rst_ni |-> !rsp_valid_i;
  endproperty

  req_to_rsp_a: assert property (req_to_rsp_p)
    else begin
      $error("Reply missing two cycles after a request");
      n_errors++;
    end
  rsp_has_req_a: assert property (rsp_has_req_p)
    else begin
      $error("Reply without a request two cycles earlier");
      n_errors++;
    end
  quiet_in_reset_a: assert property (quiet_in_reset_p)
    else begin
      $error("Reply valid while in reset");
      n_errors++;
    end

endmodule

bind soc_harness_top soc_harness_asserts asserts_i (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .req_valid_i ( req_valid_i ),
  .rsp_valid_i ( rsp_valid_o )
);

`default_nettype wire

//--- testbench/tb_soc_harness.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_harness;

  localparam int NumWords   = 1024;
  localparam int IdxW       = $clog2(NumWords);
  localparam int MaxEntries = 48;
  localparam int RspTimeout = 8;

  typedef struct packed {
    soc_bus_pkg::bus_req_t req;
    soc_bus_pkg::bus_rsp_t exp;
  } entry_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  rtc_i;
  logic                  req_valid_i;
  soc_bus_pkg::bus_req_t req_i;
  logic                  rsp_valid_o;
  soc_bus_pkg::bus_rsp_t rsp_o;
  logic                  timer_irq_o;
  logic                  ipi_o;

  entry_t      tbl [MaxEntries];
  string       names [MaxEntries];
  int          issue_cyc [MaxEntries];
  int          n_entries = 0;
  int          n_tests = 0;
  int          n_fail = 0;
  int          cyc = 0;
  logic [31:0] rng = 32'hc538;
  logic [63:0] ram_model [NumWords];

  soc_harness_top #(
    .NumWords ( NumWords )
  ) dut_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [63:0] merge_bytes(
    input logic [63:0] old_w,
    input logic [63:0] new_w,
    input logic [7:0]  be
  );
    logic [63:0] mask;
    for (int b = 0; b < 8; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift32(rng);
    r = rng;
  endtask

  task automatic add_entry(input string name, input logic [31:0] addr, input logic we,
                           input logic [7:0] be, input logic [63:0] wdata,
                           input logic [63:0] rdata, input soc_bus_pkg::resp_e resp);
    tbl[n_entries].req = '{addr: addr, we: we, be: be, wdata: wdata};
    tbl[n_entries].exp = '{rdata: rdata, resp: resp};
    names[n_entries] = name;
    n_entries++;
  endtask

  task automatic ram_write_entry(input string name, input logic [IdxW-1:0] idx,
                                 input logic [7:0] be, input logic [63:0] data);
    ram_model[idx] = merge_bytes(ram_model[idx], data, be);
    add_entry(name, soc_map_pkg::RamBase + 32'({idx, 3'b000}), 1'b1, be, data, '0,
              soc_bus_pkg::OKAY);
  endtask

  task automatic ram_read_entry(input string name, input logic [IdxW-1:0] idx);
    add_entry(name, soc_map_pkg::RamBase + 32'({idx, 3'b000}), 1'b0, 8'hff, '0,
              ram_model[idx], soc_bus_pkg::OKAY);
  endtask

  task automatic end_test(input string name, input bit ok);
    n_tests++;
    if (ok) begin
      $display("%-24s ok", name);
    end else begin
      n_fail++;
      $display("%-24s failed", name);
    end
  endtask

  task automatic check_entry(input int i);
    bit ok;
    ok = 1'b1;
    assert (rsp_o.rdata === tbl[i].exp.rdata) else begin
      $display("ERR %s rdata expected %h actual %h", names[i], tbl[i].exp.rdata, rsp_o.rdata);
      ok = 1'b0;
    end
    assert (rsp_o.resp === tbl[i].exp.resp) else begin
      $display("ERR %s resp expected %0d actual %0d", names[i], tbl[i].exp.resp, rsp_o.resp);
      ok = 1'b0;
    end
    assert (cyc - issue_cyc[i] == 2) else begin
      $display("Reply for %s came %0d cycles after its request", names[i], cyc - issue_cyc[i]);
      ok = 1'b0;
    end
    end_test(names[i], ok);
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    bit ok;
    ok = 1'b1;
    assert (act === exp) else begin
      $display("ERR %s expected %0b actual %0b", name, exp, act);
      ok = 1'b0;
    end
    end_test(name, ok);
  endtask

  // Issue entries in back-to-back cycles and check the replies in order
  task automatic apply_group(input int first, input int last);
    int sent;
    int got;
    int idle;
    sent = first;
    got  = first;
    idle = 0;
    while (got <= last && idle < RspTimeout) begin
      @(posedge clk_i);
      #1;
      if (sent <= last) begin
        req_valid_i     = 1'b1;
        req_i           = tbl[sent].req;
        issue_cyc[sent] = cyc;
        sent++;
      end else begin
        req_valid_i = 1'b0;
        req_i       = '0;
      end
      @(negedge clk_i);
      if (rsp_valid_o) begin
        check_entry(got);
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (got <= last) begin
      $display("No reply for %s within %0d cycles", names[got], RspTimeout);
      n_fail++;
    end
  endtask

  task automatic apply_each(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      apply_group(i, i);
    end
  endtask

  task automatic pulse_rtc();
    @(posedge clk_i);
    #1 rtc_i = 1'b1;
    repeat (4) @(posedge clk_i);
    #1 rtc_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  initial begin
    logic [31:0]     r0;
    logic [31:0]     r1;
    logic [IdxW-1:0] widx [4];
    int              first;
    int              waited;
    rst_ni      = 1'b0;
    rtc_i       = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // ----------------------------------------
    // ROM image and the words past its end
    first = n_entries;
    for (int i = 0; i < soc_map_pkg::RomWords; i++) begin
      add_entry($sformatf("rom_rd_%0d", i), soc_map_pkg::RomBase + 32'(i * 8), 1'b0, 8'hff,
                '0, soc_map_pkg::BootRomImage[i], soc_bus_pkg::OKAY);
    end
    add_entry("rom_rd_past_image", soc_map_pkg::RomBase + 32'h40, 1'b0, 8'hff, '0, '0,
              soc_bus_pkg::OKAY);
    add_entry("rom_rd_last_word", soc_map_pkg::RomBase + soc_map_pkg::RomLength - 32'd8,
              1'b0, 8'hff, '0, '0, soc_bus_pkg::OKAY);
    apply_each(first, n_entries - 1);

    // ----------------------------------------
    // RAM writes of full words then partial bytes
    first = n_entries;
    for (int k = 0; k < 4; k++) begin
      next_rand(r0);
      widx[k] = r0[IdxW-1:0];
      next_rand(r0);
      next_rand(r1);
      ram_write_entry($sformatf("ram_wr_full_%0d", k), widx[k], 8'hff, {r0, r1});
      next_rand(r0);
      next_rand(r1);
      // Bit 7 kept clear so the mask is never full
      ram_write_entry($sformatf("ram_wr_part_%0d", k), widx[k], (r0[7:0] & 8'h7f) | 8'h01,
                      {r1, r0});
      ram_read_entry($sformatf("ram_rd_%0d", k), widx[k]);
    end
    apply_each(first, n_entries - 1);

    // ----------------------------------------
    // Error replies
    first = n_entries;
    add_entry("unmapped_rd", 32'h4000_0000, 1'b0, 8'hff, '0, '0, soc_bus_pkg::DECERR);
    add_entry("ram_past_end", soc_map_pkg::RamBase + 32'(NumWords * 8), 1'b0, 8'hff, '0, '0,
              soc_bus_pkg::DECERR);
    add_entry("rom_wr", soc_map_pkg::RomBase + 32'h10, 1'b1, 8'hff, '1, '0,
              soc_bus_pkg::SLVERR);
    add_entry("rom_rd_after_wr", soc_map_pkg::RomBase + 32'h10, 1'b0, 8'hff, '0,
              soc_map_pkg::BootRomImage[2], soc_bus_pkg::OKAY);
    apply_each(first, n_entries - 1);

    // ----------------------------------------
    // Timer compare and software interrupt
    first = n_entries;
    add_entry("mtimecmp_wr", soc_map_pkg::ClintBase + soc_map_pkg::MtimecmpOffset, 1'b1,
              8'hff, 64'd5, '0, soc_bus_pkg::OKAY);
    apply_each(first, n_entries - 1);
    check_level("irq_low_at_start", 1'b0, timer_irq_o);
    repeat (4) pulse_rtc();
    check_level("irq_low_before_fifth", 1'b0, timer_irq_o);
    pulse_rtc();
    waited = 0;
    while (timer_irq_o !== 1'b1 && waited < RspTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    check_level("irq_high_after_fifth", 1'b1, timer_irq_o);
    first = n_entries;
    add_entry("mtime_rd", soc_map_pkg::ClintBase + soc_map_pkg::MtimeOffset, 1'b0, 8'hff,
              '0, 64'd5, soc_bus_pkg::OKAY);
    add_entry("msip_set", soc_map_pkg::ClintBase + soc_map_pkg::MsipOffset, 1'b1, 8'h01,
              64'd1, '0, soc_bus_pkg::OKAY);
    apply_each(first, n_entries - 1);
    check_level("ipi_set", 1'b1, ipi_o);
    first = n_entries;
    add_entry("msip_clear", soc_map_pkg::ClintBase + soc_map_pkg::MsipOffset, 1'b1, 8'h01,
              '0, '0, soc_bus_pkg::OKAY);
    apply_each(first, n_entries - 1);
    check_level("ipi_clear", 1'b0, ipi_o);

    // ----------------------------------------
    // Mixed targets in consecutive cycles
    first = n_entries;
    next_rand(r0);
    next_rand(r1);
    add_entry("burst_rom", soc_map_pkg::RomBase + 32'h18, 1'b0, 8'hff, '0,
              soc_map_pkg::BootRomImage[3], soc_bus_pkg::OKAY);
    ram_read_entry("burst_ram_rd", widx[0]);
    add_entry("burst_decerr", 32'hf000_0000, 1'b0, 8'hff, '0, '0, soc_bus_pkg::DECERR);
    add_entry("burst_rom_wr", soc_map_pkg::RomBase, 1'b1, 8'hff, '1, '0, soc_bus_pkg::SLVERR);
    ram_write_entry("burst_ram_wr", r0[IdxW-1:0], 8'hff, {r1, r0});
    ram_read_entry("burst_ram_back", r0[IdxW-1:0]);
    add_entry("burst_mtimecmp", soc_map_pkg::ClintBase + soc_map_pkg::MtimecmpOffset, 1'b0,
              8'hff, '0, 64'd5, soc_bus_pkg::OKAY);
    add_entry("burst_rom_last", soc_map_pkg::RomBase + 32'h38, 1'b0, 8'hff, '0,
              soc_map_pkg::BootRomImage[7], soc_bus_pkg::OKAY);
    apply_group(first, n_entries - 1);

    n_fail += dut_i.asserts_i.n_errors;
    $display("Tests run %0d, failed %0d", n_tests, n_fail);
    if (n_fail == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
source/soc_map_pkg.sv
source/soc_bus_pkg.sv
source/req_decoder.sv
source/boot_rom.sv
source/data_ram.sv
source/clint_timer.sv
source/rsp_mux.sv
source/soc_harness_top.sv
testbench/soc_harness_asserts.sv
testbench/tb_soc_harness.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_soc_harness -f sources.f -o Vtb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
echo "Pass line not found"
exit 1
